/* Bender.yml */
package:
  name: mpu

sources:
  - files:
      - pkg_mpu.sv
      - host_if_mpu.sv
      - thread_mem_mpu.sv
      - map_man_mpu.sv
      - issue_track_mpu.sv
      - dispatch_mpu.sv
      - mpu.sv
  - target: test
    files:
      - tb_mpu.sv

/* dispatch_mpu.sv */
// MPU dispatch that looks up a started thread and streams its instructions to the array
`timescale 1ns/1ps
`default_nettype none

module dispatch_mpu (
	input  wire                              clock,
	input  wire                              arst_n,
	input  wire                              start,
	input  wire  [pkg_mpu::THREAD_ID_W-1:0]  start_id,
	input  wire  [pkg_mpu::ISSUE_W-1:0]      start_no,
	output logic                             busy,
	output logic [pkg_mpu::THREAD_ID_W-1:0]  lookup_id,
	input  wire  [pkg_mpu::ADDR_W-1:0]       lookup_base,
	input  wire  [pkg_mpu::LEN_W-1:0]        lookup_len,
	input  wire                              lookup_valid,
	output logic [pkg_mpu::ADDR_W-1:0]       rd_addr,
	input  wire pkg_mpu::mpu_word_u          rd_data,
	output logic                             instr_valid,
	output pkg_mpu::mpu_word_u               instr,
	output logic [pkg_mpu::ISSUE_W-1:0]      issue_no
);
	import pkg_mpu::*;

	logic [1:0]             state;
	logic [THREAD_ID_W-1:0] cur_id;
	logic [ADDR_W-1:0]      addr;       // Next read address
	logic [LEN_W-1:0]       out_cnt;    // Words left to send

	assign busy        = start | (state != DSP_IDLE);
	assign lookup_id   = cur_id;
	assign rd_addr     = addr;
	assign instr_valid = (state == DSP_STREAM);
	assign instr       = rd_data;       // Memory output lines up with the stream

	////////////////////////////////////////////////////////////
	// FSM with idle, lookup, read and stream states
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state   <= DSP_IDLE;
			out_cnt <= '0;
		end else begin
			case (state)
				DSP_IDLE: begin
					if (start) begin
						state <= DSP_LOOKUP;
					end
				end
				DSP_LOOKUP: begin
					if (lookup_valid) begin
						state   <= DSP_READ;
						out_cnt <= lookup_len;
					end else begin
						state <= DSP_IDLE;  // No map entry so the slot waits for its commit
					end
				end
				DSP_READ: begin
					state <= DSP_STREAM;    // First word in flight
				end
				default: begin
					out_cnt <= out_cnt - 1'b1;
					if (out_cnt == LEN_W'(1)) begin
						state <= DSP_IDLE;
					end
				end
			endcase
		end
	end

	// Reads run one word ahead of the stream
	always_ff @(posedge clock) begin
		if (start) begin
			cur_id   <= start_id;
			issue_no <= start_no;
		end
		if (state == DSP_LOOKUP) begin
			addr <= lookup_base;
		end else if (state != DSP_IDLE) begin
			addr <= addr + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* host_if_mpu.sv */
// MPU host interface, Wishbone slave turning register writes into loads and runs
`timescale 1ns/1ps
`default_nettype none

module host_if_mpu (
	input  wire                              clock,
	input  wire                              arst_n,
	input  wire                              wb_cyc,
	input  wire                              wb_stb,
	input  wire                              wb_we,
	input  wire  [1:0]                       wb_adr,
	input  wire  [pkg_mpu::WORD_W-1:0]       wb_dat_w,
	output logic [pkg_mpu::WORD_W-1:0]       wb_dat_r,
	output logic                             wb_ack,
	output logic                             hdr_req,
	output logic [pkg_mpu::THREAD_ID_W-1:0]  hdr_id,
	output logic [pkg_mpu::LEN_W-1:0]        hdr_len,
	input  wire                              hdr_ack,
	input  wire                              hdr_ok,
	output logic                             instr_we,
	output pkg_mpu::mpu_word_u               instr_word,
	output logic                             run_req,
	output logic [pkg_mpu::THREAD_ID_W-1:0]  run_id,
	input  wire                              run_ok,
	input  wire  [pkg_mpu::LEN_W-1:0]        used_size,
	input  wire  [pkg_mpu::CNT_W-1:0]        outstanding,
	input  wire                              full
);
	import pkg_mpu::*;

	mpu_word_u         wdat;        // Write data in both views
	logic              new_cyc;     // First cycle of a bus access
	logic              hdr_pend;    // Header access waiting on the map decision
	logic [LEN_W-1:0]  remain;      // Words still owed to the open header
	logic              last_hdr_ok;
	logic              last_run_ok;
	logic [WORD_W-1:0] status;

	assign wdat    = wb_dat_w;
	assign new_cyc = wb_cyc & wb_stb & ~wb_ack & ~hdr_pend;

	always_comb begin
		status        = '0;
		status[6:0]   = used_size;
		status[10:8]  = outstanding;
		status[12]    = full;
		status[16]    = last_hdr_ok;
		status[17]    = last_run_ok;
	end

	////////////////////////////////////////////////////////////
	// Access decode and sticky flags
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			wb_ack      <= 1'b0;
			hdr_pend    <= 1'b0;
			hdr_req     <= 1'b0;
			instr_we    <= 1'b0;
			run_req     <= 1'b0;
			remain      <= '0;
			last_hdr_ok <= 1'b0;
			last_run_ok <= 1'b0;
		end else begin
			wb_ack   <= hdr_pend;           // Second clock of a header access
			hdr_pend <= 1'b0;
			hdr_req  <= 1'b0;
			instr_we <= 1'b0;
			run_req  <= 1'b0;
			if (hdr_ack) begin
				last_hdr_ok <= hdr_ok;
				remain      <= hdr_ok ? hdr_len : '0;
			end
			if (run_req) begin
				last_run_ok <= run_ok;
			end
			if (new_cyc) begin
				case (wb_adr)
					REG_HEADER: begin
						hdr_pend <= 1'b1;
						if (wb_we) begin
							// A header only opens once the previous one is filled,
							// so memory pointer and used size stay in step
							if (remain == '0) begin
								hdr_req <= 1'b1;
							end else begin
								last_hdr_ok <= 1'b0;
							end
						end
					end
					REG_INSTR: begin
						wb_ack <= 1'b1;
						if (wb_we && remain != '0) begin
							instr_we <= 1'b1;
							remain   <= remain - 1'b1;
						end
					end
					REG_RUN: begin
						wb_ack  <= 1'b1;
						run_req <= wb_we;
					end
					default: begin
						wb_ack <= 1'b1;             // Status read
					end
				endcase
			end
		end
	end

	always_ff @(posedge clock) begin
		if (new_cyc) begin
			wb_dat_r   <= (wb_adr == REG_STATUS) ? status : '0;
			hdr_id     <= wdat.hdr.id;
			hdr_len    <= wdat.hdr.len;
			instr_word <= wdat;
			run_id     <= wdat.hdr.id;
		end
	end

endmodule

`default_nettype wire

/* issue_track_mpu.sv */
// MPU issue tracker, hazard check on run, issue number allocation and commit table
`timescale 1ns/1ps
`default_nettype none

module issue_track_mpu (
	input  wire                              clock,
	input  wire                              arst_n,
	input  wire                              run_req,
	input  wire  [pkg_mpu::THREAD_ID_W-1:0]  run_id,
	output logic                             run_ok,
	input  wire                              busy,
	output logic                             start,
	output logic [pkg_mpu::THREAD_ID_W-1:0]  start_id,
	output logic [pkg_mpu::ISSUE_W-1:0]      start_no,
	input  wire                              commit_req,
	input  wire  [pkg_mpu::ISSUE_W-1:0]      commit_no,
	output logic [pkg_mpu::CNT_W-1:0]        outstanding,
	output logic                             full
);
	import pkg_mpu::*;

	logic [NUM_ISSUE-1:0]   slot_valid;
	logic [THREAD_ID_W-1:0] slot_id [NUM_ISSUE];
	logic [ISSUE_W-1:0]     next_no;    // Wraps modulo NUM_ISSUE
	logic                   id_hit;     // Thread still in flight

	always_comb begin
		id_hit      = 1'b0;
		outstanding = '0;
		for (int i = 0; i < NUM_ISSUE; i++) begin
			if (slot_valid[i] && slot_id[i] == run_id) begin
				id_hit = 1'b1;
			end
			outstanding = outstanding + CNT_W'(slot_valid[i]);
		end
	end

	assign full = &slot_valid;

	// Issue numbers go out in order, so the slot under the counter must be free;
	// busy from dispatch already covers a start still in flight
	assign run_ok = run_req & ~busy & ~id_hit & ~slot_valid[next_no];

	////////////////////////////////////////////////////////////
	// Slot table
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			slot_valid <= '0;
			next_no    <= '0;
			start      <= 1'b0;
		end else begin
			start <= run_ok;                // Start one clock after the run
			if (commit_req) begin
				slot_valid[commit_no] <= 1'b0;
			end
			if (run_ok) begin
				slot_valid[next_no] <= 1'b1;
				next_no             <= next_no + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (run_ok) begin
			slot_id[next_no] <= run_id;
			start_id         <= run_id;
			start_no         <= next_no;
		end
	end

endmodule

`default_nettype wire

/* map_man_mpu.sv */
// MPU map manager, per-thread base and length table with capacity check
`timescale 1ns/1ps
`default_nettype none

module map_man_mpu (
	input  wire                              clock,
	input  wire                              arst_n,
	input  wire                              hdr_req,
	input  wire  [pkg_mpu::THREAD_ID_W-1:0]  hdr_id,
	input  wire  [pkg_mpu::LEN_W-1:0]        hdr_len,
	output logic                             hdr_ack,
	output logic                             hdr_ok,
	output logic [pkg_mpu::LEN_W-1:0]        used_size,
	input  wire  [pkg_mpu::THREAD_ID_W-1:0]  lookup_id,
	output logic [pkg_mpu::ADDR_W-1:0]       lookup_base,
	output logic                             lookup_valid,
	output logic [pkg_mpu::LEN_W-1:0]        lookup_len
);
	import pkg_mpu::*;

	logic [ADDR_W-1:0]     base_tab [NUM_THREAD];
	logic [LEN_W-1:0]      len_tab  [NUM_THREAD];
	logic [NUM_THREAD-1:0] valid_tab;
	logic [LEN_W-1:0]      free_size;   // Words not yet handed out

	assign free_size = LEN_W'(MEM_DEPTH) - used_size;

	// Decision in the request cycle
	assign hdr_ack = hdr_req;
	assign hdr_ok  = hdr_req && (hdr_len != '0) && (hdr_len <= free_size);

	////////////////////////////////////////////////////////////
	// Table update
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			valid_tab <= '0;
			used_size <= '0;
		end else if (hdr_ok) begin
			valid_tab[hdr_id] <= 1'b1;
			used_size         <= used_size + hdr_len;
		end
	end

	// Reused id overwrites, old words remain allocated
	always_ff @(posedge clock) begin
		if (hdr_ok) begin
			base_tab[hdr_id] <= used_size[ADDR_W-1:0];
			len_tab[hdr_id]  <= hdr_len;
		end
	end

	// Lookup for dispatch
	assign lookup_base  = base_tab[lookup_id];
	assign lookup_len   = len_tab[lookup_id];
	assign lookup_valid = valid_tab[lookup_id];

endmodule

`default_nettype wire

/* mpu.sv */
// MPU top, host interface, thread memory, map, issue tracking and dispatch
`timescale 1ns/1ps
`default_nettype none

module mpu (
	input  wire                          clock,
	input  wire                          arst_n,
	input  wire                          wb_cyc,
	input  wire                          wb_stb,
	input  wire                          wb_we,
	input  wire  [1:0]                   wb_adr,
	input  wire  [pkg_mpu::WORD_W-1:0]   wb_dat_w,
	output logic [pkg_mpu::WORD_W-1:0]   wb_dat_r,
	output logic                         wb_ack,
	output logic                         instr_valid,
	output pkg_mpu::mpu_word_u           instr,
	output logic [pkg_mpu::ISSUE_W-1:0]  issue_no,
	input  wire                          commit_req,
	input  wire  [pkg_mpu::ISSUE_W-1:0]  commit_no
);
	import pkg_mpu::*;

	// Thread loading
	logic                   hdr_req;
	logic [THREAD_ID_W-1:0] hdr_id;
	logic [LEN_W-1:0]       hdr_len;
	logic                   hdr_ack;
	logic                   hdr_ok;
	logic                   instr_we;
	mpu_word_u              instr_word;
	logic [LEN_W-1:0]       used_size;

	// Run and issue
	logic                   run_req;
	logic [THREAD_ID_W-1:0] run_id;
	logic                   run_ok;
	logic                   start;
	logic [THREAD_ID_W-1:0] start_id;
	logic [ISSUE_W-1:0]     start_no;
	logic                   busy;
	logic [CNT_W-1:0]       outstanding;
	logic                   full;

	// Dispatch side
	logic [THREAD_ID_W-1:0] lookup_id;
	logic [ADDR_W-1:0]      lookup_base;
	logic [LEN_W-1:0]       lookup_len;
	logic                   lookup_valid;
	logic [ADDR_W-1:0]      rd_addr;
	mpu_word_u              rd_data;

	host_if_mpu host_if_mpu (
		.clock       (clock),
		.arst_n      (arst_n),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack),
		.hdr_req     (hdr_req),
		.hdr_id      (hdr_id),
		.hdr_len     (hdr_len),
		.hdr_ack     (hdr_ack),
		.hdr_ok      (hdr_ok),
		.instr_we    (instr_we),
		.instr_word  (instr_word),
		.run_req     (run_req),
		.run_id      (run_id),
		.run_ok      (run_ok),
		.used_size   (used_size),
		.outstanding (outstanding),
		.full        (full)
	);

	thread_mem_mpu thread_mem_mpu (
		.clock       (clock),
		.arst_n      (arst_n),
		.instr_we    (instr_we),
		.instr_word  (instr_word),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data)
	);

	map_man_mpu map_man_mpu (
		.clock        (clock),
		.arst_n       (arst_n),
		.hdr_req      (hdr_req),
		.hdr_id       (hdr_id),
		.hdr_len      (hdr_len),
		.hdr_ack      (hdr_ack),
		.hdr_ok       (hdr_ok),
		.used_size    (used_size),
		.lookup_id    (lookup_id),
		.lookup_base  (lookup_base),
		.lookup_valid (lookup_valid),
		.lookup_len   (lookup_len)
	);

	issue_track_mpu issue_track_mpu (
		.clock       (clock),
		.arst_n      (arst_n),
		.run_req     (run_req),
		.run_id      (run_id),
		.run_ok      (run_ok),
		.busy        (busy),
		.start       (start),
		.start_id    (start_id),
		.start_no    (start_no),
		.commit_req  (commit_req),
		.commit_no   (commit_no),
		.outstanding (outstanding),
		.full        (full)
	);

	dispatch_mpu dispatch_mpu (
		.clock        (clock),
		.arst_n       (arst_n),
		.start        (start),
		.start_id     (start_id),
		.start_no     (start_no),
		.busy         (busy),
		.lookup_id    (lookup_id),
		.lookup_base  (lookup_base),
		.lookup_len   (lookup_len),
		.lookup_valid (lookup_valid),
		.rd_addr      (rd_addr),
		.rd_data      (rd_data),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.issue_no     (issue_no)
	);

endmodule

`default_nettype wire

/* pkg_mpu.sv */
// MPU package with sizes, register map and the shared word format
`default_nettype none

package pkg_mpu;

	////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////
	localparam int WORD_W      = 32;          // Bus and instruction width
	localparam int NUM_THREAD  = 8;
	localparam int THREAD_ID_W = 3;
	localparam int MEM_DEPTH   = 64;          // Thread memory words
	localparam int ADDR_W      = 6;
	localparam int LEN_W       = 7;           // Holds 0 to 64
	localparam int NUM_ISSUE   = 4;           // Outstanding issue slots
	localparam int ISSUE_W     = 2;
	localparam int CNT_W       = ISSUE_W + 1; // Outstanding count 0 to 4

	// Register word offsets on the 2-bit Wishbone address
	localparam logic [1:0] REG_HEADER = 2'd0;
	localparam logic [1:0] REG_INSTR  = 2'd1;
	localparam logic [1:0] REG_RUN    = 2'd2;
	localparam logic [1:0] REG_STATUS = 2'd3;

	// Dispatch FSM encoding
	localparam logic [1:0] DSP_IDLE   = 2'd0;
	localparam logic [1:0] DSP_LOOKUP = 2'd1;
	localparam logic [1:0] DSP_READ   = 2'd2;
	localparam logic [1:0] DSP_STREAM = 2'd3;

	////////////////////////////////////////////////////////////
	// One 32-bit word, read as an instruction or as a thread header
	////////////////////////////////////////////////////////////
	typedef union packed {
		struct packed {
			logic [7:0]             opcode;
			logic [23:0]            operand;
		} instr;
		struct packed {
			logic [16:0]            spare_hi;
			logic [LEN_W-1:0]       len;      // Bits 14:8
			logic [4:0]             spare_lo;
			logic [THREAD_ID_W-1:0] id;       // Bits 2:0
		} hdr;
	} mpu_word_u;

endpackage

`default_nettype wire

/* sources.f */
pkg_mpu.sv
host_if_mpu.sv
thread_mem_mpu.sv
map_man_mpu.sv
issue_track_mpu.sv
dispatch_mpu.sv
mpu.sv
tb_mpu.sv

/* tb_mpu.sv */
// MPU testbench that loads and runs threads over Wishbone with an array model committing issues
`timescale 1ns/1ps
`default_nettype none

module tb_mpu;
	import pkg_mpu::*;

	localparam int CLK_PERIOD = 40;
	localparam int ACK_WAIT   = 8;          // Longest bus access allowed
	localparam int START_LAT  = 3;          // Start pulse to first instruction
	localparam int QUIET_CYC  = 10;
	localparam int BUS_OPS    = 120;        // Header, instruction, run and status accesses
	localparam int RUN_OPS    = 10;
	localparam int MARGIN     = 200;
	localparam int TEST_CYCLES = BUS_OPS * 4 + RUN_OPS * (MEM_DEPTH + QUIET_CYC)
		+ 2 * NUM_ISSUE * 6 + MARGIN;

	logic                clock = 1'b0;
	logic                arst_n;
	logic                wb_cyc;
	logic                wb_stb;
	logic                wb_we;
	logic [1:0]          wb_adr;
	logic [WORD_W-1:0]   wb_dat_w;
	logic [WORD_W-1:0]   wb_dat_r;
	logic                wb_ack;
	logic                instr_valid;
	mpu_word_u           instr;
	logic [ISSUE_W-1:0]  issue_no;
	logic                commit_req;
	logic [ISSUE_W-1:0]  commit_no;

	// Scoreboard
	mpu_word_u exp_mem [MEM_DEPTH];
	int        exp_wr;                       // Next memory word written
	int        exp_used;
	int        exp_remain;                   // Words owed to the open header
	int        exp_base [NUM_THREAD];
	int        exp_len [NUM_THREAD];
	bit        exp_mapped [NUM_THREAD];
	bit        exp_slot_valid [NUM_ISSUE];
	int        exp_slot_id [NUM_ISSUE];
	int        exp_slot_len [NUM_ISSUE];     // Words the array should collect
	int        exp_next_no;
	bit        exp_hdr_ok;
	bit        exp_run_ok;
	int        got_cnt [NUM_ISSUE];          // Words collected per issue number
	int        err_value;
	int        err_other;
	integer    seed;

	mpu dut (
		.clock       (clock),
		.arst_n      (arst_n),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack),
		.instr_valid (instr_valid),
		.instr       (instr),
		.issue_no    (issue_no),
		.commit_req  (commit_req),
		.commit_no   (commit_no)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	////////////////////////////////////////////////////////////
	// Bus and reset properties
	////////////////////////////////////////////////////////////
	ack_single: assert property (@(posedge clock) disable iff (!arst_n) wb_ack |=> !wb_ack)
		else begin
			err_other++;
			$display("Wishbone ack stayed high for two cycles at %0t", $time);
		end

	ack_in_cycle: assert property (@(posedge clock) disable iff (!arst_n)
		$rose(wb_ack) |-> $past(wb_cyc && wb_stb))
		else begin
			err_other++;
			$display("Wishbone ack raised outside an active cycle at %0t", $time);
		end

	reset_quiet: assert property (@(posedge clock)
		(!arst_n || $rose(arst_n)) |-> (!instr_valid && !wb_ack))
		else begin
			err_other++;
			$display("Stream or ack active during or right after reset at %0t", $time);
		end

	// Array model counting streamed words per issue number
	always @(negedge clock) begin
		if (arst_n === 1'b1 && instr_valid === 1'b1) begin
			got_cnt[issue_no] += 1;
		end
	end

	task automatic compare_value(input string name, input logic [WORD_W-1:0] got,
			input logic [WORD_W-1:0] exp);
		assert (got === exp) else begin
			err_value++;
			$display("[ERROR] %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Wishbone access that starts and ends on a falling edge
	////////////////////////////////////////////////////////////
	task automatic wb_access(input logic we, input logic [1:0] adr,
			input logic [WORD_W-1:0] wdat, output logic [WORD_W-1:0] rdat);
		int n;
		n = 0;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdat;
		do begin
			@(negedge clock);
			n++;
		end while (wb_ack !== 1'b1 && n < ACK_WAIT);
		if (wb_ack !== 1'b1) begin
			err_other++;
			$display("No Wishbone ack for register %0d at %0t", adr, $time);
		end else begin
			compare_value("wb_ack latency", WORD_W'(n), (adr == REG_HEADER) ? 2 : 1);
		end
		rdat   = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		@(negedge clock);                   // Idle cycle between accesses
	endtask

	task automatic write_header(input int id, input int len);
		mpu_word_u         w;
		logic [WORD_W-1:0] rd;
		w              = '0;
		w.hdr.spare_hi = 17'($random(seed));  // Spare bits are ignored
		w.hdr.id       = THREAD_ID_W'(id);
		w.hdr.len      = LEN_W'(len);
		wb_access(1'b1, REG_HEADER, w, rd);
		if (exp_remain == 0 && len != 0 && len <= MEM_DEPTH - exp_used) begin
			exp_base[id]   = exp_used;
			exp_len[id]    = len;
			exp_mapped[id] = 1'b1;
			exp_used       += len;
			exp_remain     = len;
			exp_hdr_ok     = 1'b1;
		end else begin
			exp_hdr_ok = 1'b0;
		end
	endtask

	task automatic write_instr(input logic [WORD_W-1:0] word);
		logic [WORD_W-1:0] rd;
		wb_access(1'b1, REG_INSTR, word, rd);
		if (exp_remain > 0) begin
			exp_mem[exp_wr] = word;
			exp_wr++;
			exp_remain--;
		end
	endtask

	task automatic load_thread(input int id, input int len);
		write_header(id, len);
		for (int i = 0; i < len; i++) begin
			write_instr($random(seed));
		end
	endtask

	task automatic check_status();
		logic [WORD_W-1:0] rd;
		logic [WORD_W-1:0] exp;
		int                cnt;
		cnt = 0;
		for (int i = 0; i < NUM_ISSUE; i++) begin
			cnt += int'(exp_slot_valid[i]);
		end
		exp        = '0;
		exp[6:0]   = LEN_W'(exp_used);
		exp[10:8]  = CNT_W'(cnt);
		exp[12]    = (cnt == NUM_ISSUE);
		exp[16]    = exp_hdr_ok;
		exp[17]    = exp_run_ok;
		wb_access(1'b0, REG_STATUS, '0, rd);
		compare_value("wb_dat_r status", rd, exp);
	endtask

	////////////////////////////////////////////////////////////
	// Run request and stream check
	////////////////////////////////////////////////////////////
	task automatic run_thread(input int id);
		mpu_word_u         w;
		logic [WORD_W-1:0] rd;
		bit                hit;
		bit                ok;
		int                no;
		int                n;
		hit = 1'b0;
		for (int i = 0; i < NUM_ISSUE; i++) begin
			if (exp_slot_valid[i] && exp_slot_id[i] == id) begin
				hit = 1'b1;
			end
		end
		no         = exp_next_no;
		ok         = !hit && !exp_slot_valid[no];   // Issue goes to the slot under the counter
		exp_run_ok = ok;
		w          = '0;
		w.hdr.id   = THREAD_ID_W'(id);
		wb_access(1'b1, REG_RUN, w, rd);      // Returns on the start pulse
		if (ok) begin
			exp_slot_valid[no] = 1'b1;
			exp_slot_id[no]    = id;
			exp_slot_len[no]   = exp_mapped[id] ? exp_len[id] : 0;
			exp_next_no        = (no + 1) % NUM_ISSUE;
		end
		if (ok && exp_mapped[id]) begin
			n = 0;
			while (instr_valid !== 1'b1 && n <= START_LAT + QUIET_CYC) begin
				@(negedge clock);
				n++;
			end
			if (instr_valid !== 1'b1) begin
				err_other++;
				$display("Thread %0d was started but no instruction came out", id);
			end else begin
				compare_value("start to instr_valid cycles", WORD_W'(n), START_LAT);
				for (int i = 0; i < exp_len[id]; i++) begin
					compare_value("instr_valid", WORD_W'(instr_valid), 1);
					compare_value("instr", instr, exp_mem[exp_base[id] + i]);
					compare_value("issue_no", WORD_W'(issue_no), no);
					@(negedge clock);
				end
				compare_value("instr_valid after burst", WORD_W'(instr_valid), 0);
			end
		end else begin
			for (int i = 0; i < QUIET_CYC; i++) begin
				compare_value("instr_valid", WORD_W'(instr_valid), 0);
				@(negedge clock);
			end
		end
	endtask

	// Array commits every outstanding issue in random order after random gaps
	task automatic commit_random();
		int pend[$];
		int k;
		int no;
		for (int i = 0; i < NUM_ISSUE; i++) begin
			if (exp_slot_valid[i]) begin
				pend.push_back(i);
			end
		end
		while (pend.size() > 0) begin
			k  = {$random(seed)} % pend.size();
			no = pend[k];
			pend.delete(k);
			repeat ({$random(seed)} % 4 + 1) @(negedge clock);
			compare_value("words collected for issue", got_cnt[no], exp_slot_len[no]);
			commit_req = 1'b1;
			commit_no  = ISSUE_W'(no);
			@(negedge clock);
			commit_req         = 1'b0;
			got_cnt[no]        = 0;
			exp_slot_valid[no] = 1'b0;
			check_status();                 // Outstanding drops by one
		end
		@(negedge clock);
	endtask

	initial begin
		seed        = 40;
		err_value   = 0;
		err_other   = 0;
		arst_n      = 1'b0;
		wb_cyc      = 1'b0;
		wb_stb      = 1'b0;
		wb_we       = 1'b0;
		wb_adr      = '0;
		wb_dat_w    = '0;
		commit_req  = 1'b0;
		commit_no   = '0;
		exp_wr      = 0;
		exp_used    = 0;
		exp_remain  = 0;
		exp_next_no = 0;
		exp_hdr_ok  = 1'b0;
		exp_run_ok  = 1'b0;
		for (int i = 0; i < NUM_THREAD; i++) begin
			exp_mapped[i] = 1'b0;
		end
		for (int i = 0; i < NUM_ISSUE; i++) begin
			exp_slot_valid[i] = 1'b0;
			got_cnt[i]        = 0;
		end
		repeat (2) @(negedge clock);
		arst_n = 1'b1;
		@(negedge clock);
		check_status();

		// Loading several threads
		load_thread(0, 5);
		load_thread(1, 3);
		load_thread(2, 8);
		load_thread(3, 4);
		load_thread(4, 2);
		check_status();

		// Dropped word, zero length and overflow headers
		write_instr($random(seed));
		write_header(6, 0);
		check_status();
		write_header(6, 60);
		check_status();
		load_thread(5, 6);
		load_thread(7, 36);                 // Fills memory exactly
		write_header(6, 1);
		check_status();

		// Runs, hazard refusal and full slots
		run_thread(0);
		run_thread(1);
		run_thread(2);
		run_thread(0);                      // Still outstanding
		check_status();
		run_thread(7);
		run_thread(4);                      // All slots taken
		check_status();

		// Commits and then issue numbers that wrap
		commit_random();
		check_status();
		run_thread(4);
		run_thread(0);
		run_thread(6);                      // Unmapped but holds a slot
		run_thread(5);
		check_status();
		commit_random();
		check_status();

		$display("Errors: %0d value mismatches, %0d other failures", err_value, err_other);
		if (err_value + err_other == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(TEST_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run did not complete", TEST_CYCLES);
		$display("Errors: %0d value mismatches, %0d other failures", err_value, err_other);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* thread_mem_mpu.sv */
// MPU thread memory, append-only instruction store with a registered read port
`timescale 1ns/1ps
`default_nettype none

module thread_mem_mpu (
	input  wire                          clock,
	input  wire                          arst_n,
	input  wire                          instr_we,
	input  wire pkg_mpu::mpu_word_u      instr_word,
	input  wire  [pkg_mpu::ADDR_W-1:0]   rd_addr,
	output pkg_mpu::mpu_word_u           rd_data
);
	import pkg_mpu::*;

	mpu_word_u         mem [MEM_DEPTH]; // Instruction words
	logic [ADDR_W-1:0] wr_ptr;          // Next free word

	////////////////////////////////////////////////////////////
	// Write side
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
		end else if (instr_we) begin
			wr_ptr <= wr_ptr + 1'b1;        // Only reset reclaims space
		end
	end

	always_ff @(posedge clock) begin
		if (instr_we) begin
			mem[wr_ptr] <= instr_word;
		end
	end

	////////////////////////////////////////////////////////////
	// Read side, one clock latency
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire
